// ==== src/rob_pkg.sv ====
package rob_pkg;

    ////////////////////////////////////////////////////////////
    // buffer geometry
    ////////////////////////////////////////////////////////////

    // 64 entries, 6 bit id
    localparam int ROB_DEPTH = 64;
    localparam int ROB_IDX_W = 6;
    // dispatch, writeback and commit all two wide
    localparam int DISP_W    = 2;
    // two source operands per dispatch slot
    localparam int SRC_N     = 2 * DISP_W;
    // flip tables: sources, tails, own write ids
    localparam int FLIP_RD_N = SRC_N + 2 * DISP_W;
    // data table: sources plus the two tails
    localparam int DATA_RD_N = SRC_N + DISP_W;

    // field widths
    localparam int AREG_W = 5;
    localparam int WORD_W = 32;
    localparam int OCC_W  = ROB_IDX_W + 1;

    typedef logic [ROB_IDX_W-1:0] rob_id_t;
    typedef logic [AREG_W-1:0]    areg_t;
    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [OCC_W-1:0]     occ_t;

    ////////////////////////////////////////////////////////////
    // entry layouts
    ////////////////////////////////////////////////////////////

    // info entry | areg | pc | w_reg |
    localparam int INFO_W        = AREG_W + WORD_W + 1;
    localparam int INFO_AREG_LSB = WORD_W + 1;
    localparam int INFO_PC_LSB   = 1;
    localparam int INFO_WREG_BIT = 0;
    // data entry | data | exc |
    localparam int DATA_W        = WORD_W + 1;
    localparam int DATA_WORD_LSB = 1;
    localparam int DATA_EXC_BIT  = 0;

endpackage

// ==== src/rob_if.sv ====
////////////////////////////////////////////////////////////
// allocation and retirement bookkeeping
////////////////////////////////////////////////////////////

interface rob_alloc_if
    import rob_pkg::*;
();

    // from the allocator
    logic    [DISP_W-1:0] alloc_we;
    rob_id_t [DISP_W-1:0] alloc_id;
    occ_t                 occupancy;
    // from the commit side
    logic    [DISP_W-1:0] retire;
    // oldest and second oldest
    rob_id_t [DISP_W-1:0] tail_id;

    modport alloc (
        output alloc_we, alloc_id, occupancy,
        input  retire
    );

    modport tracker (
        input alloc_we, alloc_id, tail_id
    );

    modport commit (
        input  occupancy,
        output retire, tail_id
    );

endinterface

////////////////////////////////////////////////////////////
// common data bus writeback
////////////////////////////////////////////////////////////

interface rob_wb_if
    import rob_pkg::*;
();

    logic    [DISP_W-1:0] wb_we;
    rob_id_t [DISP_W-1:0] wb_id;
    word_t   [DISP_W-1:0] wb_data;
    logic    [DISP_W-1:0] wb_exc;

    modport src  (output wb_we, wb_id, wb_data, wb_exc);
    modport sink (input  wb_we, wb_id, wb_data, wb_exc);

endinterface

// ==== src/multiport_regfile.sv ====
module multiport_regfile
    import rob_pkg::*;
#(
    parameter int DATA_WIDTH = 1,
    parameter int R_PORTS    = 1,
    parameter int W_PORTS    = 1
) (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic                                clr_i,
    input  rob_id_t [R_PORTS-1:0]               raddr_i,
    output logic    [R_PORTS-1:0][DATA_WIDTH-1:0] rdata_o,
    input  rob_id_t [W_PORTS-1:0]               waddr_i,
    input  logic    [W_PORTS-1:0]               we_i,
    input  logic    [W_PORTS-1:0][DATA_WIDTH-1:0] wdata_i
);

    // one row per rob entry
    logic [DATA_WIDTH-1:0] mem_q [ROB_DEPTH];

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int e = 0; e < ROB_DEPTH; e++) begin
                mem_q[e] <= '0;
            end
        end else if (clr_i) begin
            // sync clear beats any write in the same cycle
            for (int e = 0; e < ROB_DEPTH; e++) begin
                mem_q[e] <= '0;
            end
        end else begin
            // later port overrides on address collision
            for (int w = 0; w < W_PORTS; w++) begin
                if (we_i[w]) begin
                    mem_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////

    // plain mux per port, no write bypass
    for (genvar r = 0; r < R_PORTS; r++) begin : g_rd
        assign rdata_o[r] = mem_q[raddr_i[r]];
    end

endmodule

// ==== src/rob_alloc.sv ====
module rob_alloc
    import rob_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              flush_i,
    input  logic [DISP_W-1:0] disp_valid_i,
    output logic              full_o,
    rob_alloc_if.alloc        alloc_o
);

    // newest free slot and entries in flight
    rob_id_t head_q;
    occ_t    occ_q;

    logic [DISP_W-1:0] alloc_we;
    logic              disp_ok;
    occ_t              disp_cnt;
    occ_t              ret_cnt;

    ////////////////////////////////////////////////////////////
    // slot assignment
    ////////////////////////////////////////////////////////////

    // full once fewer than two entries are free
    assign full_o  = occ_q > occ_t'(ROB_DEPTH - 2);
    assign disp_ok = !flush_i && !full_o;

    // slot 1 only rides behind slot 0
    assign alloc_we[0] = disp_valid_i[0] && disp_ok;
    assign alloc_we[1] = disp_valid_i[1] && disp_valid_i[0] && disp_ok;

    // ids go out from the current head, wrap is free at 6 bits
    for (genvar d = 0; d < DISP_W; d++) begin : g_id
        assign alloc_o.alloc_id[d] = head_q + rob_id_t'(d);
    end

    assign alloc_o.alloc_we  = alloc_we;
    assign alloc_o.occupancy = occ_q;

    // dispatched and retired counts this cycle
    always_comb begin
        disp_cnt = '0;
        ret_cnt  = '0;
        for (int d = 0; d < DISP_W; d++) begin
            disp_cnt = disp_cnt + occ_t'(alloc_we[d]);
            ret_cnt  = ret_cnt + occ_t'(alloc_o.retire[d]);
        end
    end

    ////////////////////////////////////////////////////////////
    // head and occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q <= '0;
            occ_q  <= '0;
        end else if (flush_i) begin
            head_q <= '0;
            occ_q  <= '0;
        end else begin
            head_q <= head_q + rob_id_t'(disp_cnt);
            occ_q  <= occ_q + disp_cnt - ret_cnt;
        end
    end

endmodule

// ==== src/complete_tracker.sv ====
module complete_tracker
    import rob_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                flush_i,
    rob_alloc_if.tracker        al_i,
    rob_wb_if.sink              wb_i,
    input  rob_id_t [SRC_N-1:0] src_id_i,
    output logic    [SRC_N-1:0] src_complete_o,
    output logic   [DISP_W-1:0] tail_complete_o
);

    // read ports: sources, then tails, then own write ids
    rob_id_t [FLIP_RD_N-1:0]      disp_raddr;
    rob_id_t [FLIP_RD_N-1:0]      wb_raddr;
    logic    [FLIP_RD_N-1:0][0:0] disp_rd;
    logic    [FLIP_RD_N-1:0][0:0] wb_rd;
    // toggled bits going back in
    logic    [DISP_W-1:0][0:0]    disp_wbit;
    logic    [DISP_W-1:0][0:0]    wb_wbit;

    ////////////////////////////////////////////////////////////
    // port mapping and agreement compare
    ////////////////////////////////////////////////////////////

    for (genvar s = 0; s < SRC_N; s++) begin : g_src
        assign disp_raddr[s]     = src_id_i[s];
        assign wb_raddr[s]       = src_id_i[s];
        // equal bits mean the result has landed
        assign src_complete_o[s] = ~(disp_rd[s] ^ wb_rd[s]);
    end

    for (genvar d = 0; d < DISP_W; d++) begin : g_slot
        assign disp_raddr[SRC_N+d]        = al_i.tail_id[d];
        assign wb_raddr[SRC_N+d]          = al_i.tail_id[d];
        assign tail_complete_o[d]         = ~(disp_rd[SRC_N+d] ^ wb_rd[SRC_N+d]);
        // each table flips its own bit at the written id
        assign disp_raddr[SRC_N+DISP_W+d] = al_i.alloc_id[d];
        assign wb_raddr[SRC_N+DISP_W+d]   = wb_i.wb_id[d];
        assign disp_wbit[d]               = ~disp_rd[SRC_N+DISP_W+d];
        assign wb_wbit[d]                 = ~wb_rd[SRC_N+DISP_W+d];
    end

    ////////////////////////////////////////////////////////////
    // flip tables
    ////////////////////////////////////////////////////////////

    // dispatch side, flush wipes both tables back into agreement
    multiport_regfile #(
        .DATA_WIDTH (1),
        .R_PORTS    (FLIP_RD_N),
        .W_PORTS    (DISP_W)
    ) u_disp_flip (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clr_i    (flush_i),
        .raddr_i  (disp_raddr),
        .rdata_o  (disp_rd),
        .waddr_i  (al_i.alloc_id),
        .we_i     (al_i.alloc_we),
        .wdata_i  (disp_wbit)
    );

    // writeback side
    multiport_regfile #(
        .DATA_WIDTH (1),
        .R_PORTS    (FLIP_RD_N),
        .W_PORTS    (DISP_W)
    ) u_wb_flip (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clr_i    (flush_i),
        .raddr_i  (wb_raddr),
        .rdata_o  (wb_rd),
        .waddr_i  (wb_i.wb_id),
        .we_i     (wb_i.wb_we),
        .wdata_i  (wb_wbit)
    );

endmodule

// ==== src/rob_commit.sv ====
module rob_commit
    import rob_pkg::*;
(
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          flush_i,
    rob_alloc_if.commit                   al_i,
    input  logic [DISP_W-1:0]             tail_complete_i,
    input  logic [DISP_W-1:0][INFO_W-1:0] info_rdata_i,
    input  logic [DISP_W-1:0][DATA_W-1:0] data_rdata_i,
    output logic [DISP_W-1:0]             commit_valid_o,
    output areg_t [DISP_W-1:0]            commit_areg_o,
    output word_t [DISP_W-1:0]            commit_data_o,
    output logic [DISP_W-1:0]             commit_w_reg_o,
    output logic [DISP_W-1:0]             commit_exc_o
);

    // oldest live entry
    rob_id_t tail_q;
    rob_id_t ret_cnt;

    ////////////////////////////////////////////////////////////
    // in-order selection
    ////////////////////////////////////////////////////////////

    assign al_i.tail_id[0] = tail_q;
    assign al_i.tail_id[1] = tail_q + rob_id_t'(1);

    // slot 1 never passes an incomplete slot 0
    assign commit_valid_o[0] = (al_i.occupancy >= occ_t'(1)) && tail_complete_i[0];
    assign commit_valid_o[1] = commit_valid_o[0] && (al_i.occupancy >= occ_t'(2))
                               && tail_complete_i[1];

    // architectural side always takes what is offered
    assign al_i.retire = commit_valid_o;
    assign ret_cnt     = rob_id_t'(commit_valid_o[0]) + rob_id_t'(commit_valid_o[1]);

    // unpack tail entries
    for (genvar d = 0; d < DISP_W; d++) begin : g_out
        assign commit_areg_o[d]  = info_rdata_i[d][INFO_AREG_LSB +: AREG_W];
        assign commit_w_reg_o[d] = info_rdata_i[d][INFO_WREG_BIT];
        assign commit_data_o[d]  = data_rdata_i[d][DATA_WORD_LSB +: WORD_W];
        // exception only reported, no recovery here
        assign commit_exc_o[d]   = data_rdata_i[d][DATA_EXC_BIT];
    end

    ////////////////////////////////////////////////////////////
    // tail pointer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tail_q <= '0;
        end else if (flush_i) begin
            tail_q <= '0;
        end else begin
            tail_q <= tail_q + ret_cnt;
        end
    end

endmodule

// ==== src/rob_top.sv ====
module rob_top
    import rob_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 flush_i,
    input  logic    [DISP_W-1:0] disp_valid_i,
    input  areg_t   [DISP_W-1:0] disp_areg_i,
    input  word_t   [DISP_W-1:0] disp_pc_i,
    input  logic    [DISP_W-1:0] disp_w_reg_i,
    input  rob_id_t [SRC_N-1:0]  src_id_i,
    input  logic    [DISP_W-1:0] wb_valid_i,
    input  rob_id_t [DISP_W-1:0] wb_id_i,
    input  word_t   [DISP_W-1:0] wb_data_i,
    input  logic    [DISP_W-1:0] wb_exc_i,
    output logic                 full_o,
    output rob_id_t [DISP_W-1:0] alloc_id_o,
    output word_t   [SRC_N-1:0]  src_data_o,
    output logic    [SRC_N-1:0]  src_complete_o,
    output logic    [DISP_W-1:0] commit_valid_o,
    output areg_t   [DISP_W-1:0] commit_areg_o,
    output word_t   [DISP_W-1:0] commit_data_o,
    output logic    [DISP_W-1:0] commit_w_reg_o,
    output logic    [DISP_W-1:0] commit_exc_o
);

    rob_alloc_if al_if ();
    rob_wb_if    wb_if ();

    logic    [DISP_W-1:0][INFO_W-1:0]    info_wdata;
    logic    [DISP_W-1:0][INFO_W-1:0]    info_rd;
    logic    [DISP_W-1:0][DATA_W-1:0]    data_wdata;
    rob_id_t [DATA_RD_N-1:0]             data_raddr;
    logic    [DATA_RD_N-1:0][DATA_W-1:0] data_rd;
    logic    [DISP_W-1:0][DATA_W-1:0]    data_tail;
    logic    [DISP_W-1:0]                tail_complete;

    ////////////////////////////////////////////////////////////
    // wiring
    ////////////////////////////////////////////////////////////

    // cdb ports straight onto the writeback bundle
    assign wb_if.wb_we   = wb_valid_i;
    assign wb_if.wb_id   = wb_id_i;
    assign wb_if.wb_data = wb_data_i;
    assign wb_if.wb_exc  = wb_exc_i;
    assign alloc_id_o    = al_if.alloc_id;

    for (genvar d = 0; d < DISP_W; d++) begin : g_pack
        assign info_wdata[d][INFO_AREG_LSB +: AREG_W] = disp_areg_i[d];
        assign info_wdata[d][INFO_PC_LSB +: WORD_W]   = disp_pc_i[d];
        assign info_wdata[d][INFO_WREG_BIT]           = disp_w_reg_i[d];
        assign data_wdata[d][DATA_WORD_LSB +: WORD_W] = wb_if.wb_data[d];
        assign data_wdata[d][DATA_EXC_BIT]            = wb_if.wb_exc[d];
        // tail reads sit above the operand reads
        assign data_raddr[SRC_N+d] = al_if.tail_id[d];
        assign data_tail[d]        = data_rd[SRC_N+d];
    end

    for (genvar s = 0; s < SRC_N; s++) begin : g_src
        assign data_raddr[s] = src_id_i[s];
        assign src_data_o[s] = data_rd[s][DATA_WORD_LSB +: WORD_W];
    end

    ////////////////////////////////////////////////////////////
    // storage and control blocks
    ////////////////////////////////////////////////////////////

    // areg, pc and w_reg per entry, written at dispatch
    multiport_regfile #(
        .DATA_WIDTH (INFO_W),
        .R_PORTS    (DISP_W),
        .W_PORTS    (DISP_W)
    ) u_info_tbl (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clr_i    (1'b0),
        .raddr_i  (al_if.tail_id),
        .rdata_o  (info_rd),
        .waddr_i  (al_if.alloc_id),
        .we_i     (al_if.alloc_we),
        .wdata_i  (info_wdata)
    );

    // result and exception per entry, written by the cdb
    multiport_regfile #(
        .DATA_WIDTH (DATA_W),
        .R_PORTS    (DATA_RD_N),
        .W_PORTS    (DISP_W)
    ) u_data_tbl (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clr_i    (1'b0),
        .raddr_i  (data_raddr),
        .rdata_o  (data_rd),
        .waddr_i  (wb_if.wb_id),
        .we_i     (wb_if.wb_we),
        .wdata_i  (data_wdata)
    );

    rob_alloc u_alloc (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .disp_valid_i (disp_valid_i),
        .full_o       (full_o),
        .alloc_o      (al_if.alloc)
    );

    complete_tracker u_tracker (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .flush_i         (flush_i),
        .al_i            (al_if.tracker),
        .wb_i            (wb_if.sink),
        .src_id_i        (src_id_i),
        .src_complete_o  (src_complete_o),
        .tail_complete_o (tail_complete)
    );

    rob_commit u_commit (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .flush_i         (flush_i),
        .al_i            (al_if.commit),
        .tail_complete_i (tail_complete),
        .info_rdata_i    (info_rd),
        .data_rdata_i    (data_tail),
        .commit_valid_o  (commit_valid_o),
        .commit_areg_o   (commit_areg_o),
        .commit_data_o   (commit_data_o),
        .commit_w_reg_o  (commit_w_reg_o),
        .commit_exc_o    (commit_exc_o)
    );

endmodule

// ==== verif/rob_assert.sv ====
module rob_assert
    import rob_pkg::*;
(
    input logic              clk,
    input logic              arst_n_i,
    input logic              flush_i,
    input logic [DISP_W-1:0] disp_valid_i,
    input logic              full_o,
    input logic [DISP_W-1:0] commit_valid_o
);

    timeunit 1ns;
    timeprecision 100ps;

    ////////////////////////////////////////////////////////////
    // dispatch side
    ////////////////////////////////////////////////////////////

    // no second slot while fewer than two entries are free
    a_full_no_dual: assert property (
        @(posedge clk) disable iff (!arst_n_i) full_o |-> !disp_valid_i[1]
    ) else $error("slot 1 dispatch while full_o is high");

    // slot 1 only rides behind slot 0
    a_disp_order: assert property (
        @(posedge clk) disable iff (!arst_n_i) disp_valid_i[1] |-> disp_valid_i[0]
    ) else $error("slot 1 dispatch without slot 0");

    ////////////////////////////////////////////////////////////
    // commit side
    ////////////////////////////////////////////////////////////

    a_commit_order: assert property (
        @(posedge clk) disable iff (!arst_n_i) commit_valid_o[1] |-> commit_valid_o[0]
    ) else $error("commit slot 1 valid without slot 0");

    // buffer is empty right after a flush
    a_flush_empty: assert property (
        @(posedge clk) disable iff (!arst_n_i) flush_i |=> (commit_valid_o == '0)
    ) else $error("commit valid in the cycle after flush");

endmodule

// ==== verif/rob_tb.sv ====
module rob_tb
    import rob_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] LCG_SEED    = 32'h46ca9750;
    localparam int          FILL_LIMIT  = 400;
    localparam int          DRAIN_LIMIT = 1000;

    // one model entry per allocated rob slot, oldest first
    typedef struct packed {
        rob_id_t id;
        areg_t   areg;
        word_t   pc;
        logic    w_reg;
        logic    done;
        word_t   data;
        logic    exc;
    } entry_t;

    logic                 clk;
    logic                 arst_n_i;
    logic                 flush_i;
    logic    [DISP_W-1:0] disp_valid_i;
    areg_t   [DISP_W-1:0] disp_areg_i;
    word_t   [DISP_W-1:0] disp_pc_i;
    logic    [DISP_W-1:0] disp_w_reg_i;
    rob_id_t [SRC_N-1:0]  src_id_i;
    logic    [DISP_W-1:0] wb_valid_i;
    rob_id_t [DISP_W-1:0] wb_id_i;
    word_t   [DISP_W-1:0] wb_data_i;
    logic    [DISP_W-1:0] wb_exc_i;
    logic                 full_o;
    rob_id_t [DISP_W-1:0] alloc_id_o;
    word_t   [SRC_N-1:0]  src_data_o;
    logic    [SRC_N-1:0]  src_complete_o;
    logic    [DISP_W-1:0] commit_valid_o;
    areg_t   [DISP_W-1:0] commit_areg_o;
    word_t   [DISP_W-1:0] commit_data_o;
    logic    [DISP_W-1:0] commit_w_reg_o;
    logic    [DISP_W-1:0] commit_exc_o;

    // model state and stimulus knobs
    entry_t      model_q[$];
    rob_id_t     head_id;
    logic [31:0] lcg_state;
    int          p_disp;
    int          p_wb;
    logic        force_flush;
    logic        timed_out;
    // bookkeeping
    int test_errs;
    int test_checks;
    int total_errs;
    int total_checks;
    int tests_run;
    int tests_failed;
    int dual_seen;
    int src_done_seen;
    int src_wait_seen;

    rob_top i_rob_top (.*);

    bind rob_top rob_assert u_rob_assert (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .disp_valid_i   (disp_valid_i),
        .full_o         (full_o),
        .commit_valid_o (commit_valid_o)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // random numbers and checks
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits only, low lcg bits are weak
    function automatic int rand_below(int n);
        logic [31:0] r;
        r = lcg_next();
        return int'({16'd0, r[31:16]} % 32'(n));
    endfunction

    task automatic check_eq(string name, logic [31:0] got, logic [31:0] exp);
        test_checks++;
        assert (got === exp) else begin
            $display("** Error @ %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_seen(string what, int count);
        test_checks++;
        assert (count > 0) else begin
            $display("%s never happened in this test", what);
            test_errs++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one clock cycle: drive, compare, advance the model
    ////////////////////////////////////////////////////////////

    task automatic run_cycle();
        int     pend[$];
        int     src_idx[SRC_N];
        int     wb_idx[DISP_W];
        int     n_disp;
        int     n_wb;
        int     n_ret;
        int     k;
        logic   do_flush;
        entry_t e;

        @(negedge clk);
        do_flush = force_flush;
        // dispatch only with two free entries
        n_disp = 0;
        if (model_q.size() <= ROB_DEPTH - 2 && rand_below(100) < p_disp) begin
            n_disp = 1 + rand_below(DISP_W);
        end
        for (int d = 0; d < DISP_W; d++) begin
            disp_valid_i[d] = d < n_disp;
            disp_areg_i[d]  = areg_t'(lcg_next());
            disp_pc_i[d]    = lcg_next();
            disp_w_reg_i[d] = rand_below(2) == 1;
        end
        // writebacks to distinct outstanding entries
        for (int i = 0; i < model_q.size(); i++) begin
            if (!model_q[i].done) begin
                pend.push_back(i);
            end
        end
        n_wb = 0;
        if (rand_below(100) < p_wb) begin
            n_wb = 1 + rand_below(DISP_W);
        end
        if (n_wb > pend.size()) begin
            n_wb = pend.size();
        end
        for (int w = 0; w < DISP_W; w++) begin
            wb_idx[w]     = -1;
            wb_valid_i[w] = w < n_wb;
            wb_data_i[w]  = lcg_next();
            wb_exc_i[w]   = rand_below(8) == 0;
            if (w < n_wb) begin
                k         = rand_below(pend.size());
                wb_idx[w] = pend[k];
                pend.delete(k);
                wb_id_i[w] = model_q[wb_idx[w]].id;
            end else begin
                wb_id_i[w] = rob_id_t'(lcg_next());
            end
        end
        // operand reads inside the allocated range
        for (int s = 0; s < SRC_N; s++) begin
            src_idx[s] = -1;
            if (model_q.size() > 0) begin
                src_idx[s]  = rand_below(model_q.size());
                src_id_i[s] = model_q[src_idx[s]].id;
            end else begin
                src_id_i[s] = rob_id_t'(lcg_next());
            end
        end
        flush_i = do_flush;

        // outputs settled, registered state still from the last edge
        #2;
        check_eq("alloc_id_o[0]", 32'(alloc_id_o[0]), 32'(head_id));
        check_eq("alloc_id_o[1]", 32'(alloc_id_o[1]), 32'(rob_id_t'(head_id + rob_id_t'(1))));
        check_eq("full_o", 32'(full_o), 32'(model_q.size() > ROB_DEPTH - 2));
        // complete entries at the front, at most two
        n_ret = 0;
        while (n_ret < DISP_W && n_ret < model_q.size() && model_q[n_ret].done) begin
            n_ret++;
        end
        check_eq("commit_valid_o", 32'(commit_valid_o), 32'((1 << n_ret) - 1));
        for (int d = 0; d < n_ret; d++) begin
            e = model_q[d];
            check_eq($sformatf("commit_areg_o[%0d]", d), 32'(commit_areg_o[d]), 32'(e.areg));
            check_eq($sformatf("commit_w_reg_o[%0d]", d), 32'(commit_w_reg_o[d]), 32'(e.w_reg));
            check_eq($sformatf("commit_data_o[%0d]", d), commit_data_o[d], e.data);
            check_eq($sformatf("commit_exc_o[%0d]", d), 32'(commit_exc_o[d]), 32'(e.exc));
        end
        if (n_ret == DISP_W) begin
            dual_seen++;
        end
        for (int s = 0; s < SRC_N; s++) begin
            if (src_idx[s] >= 0) begin
                e = model_q[src_idx[s]];
                check_eq($sformatf("src_complete_o[%0d]", s), 32'(src_complete_o[s]),
                         32'(e.done));
                if (e.done) begin
                    check_eq($sformatf("src_data_o[%0d]", s), src_data_o[s], e.data);
                    src_done_seen++;
                end else begin
                    src_wait_seen++;
                end
            end
        end

        // next state, as of the coming rising edge
        if (do_flush) begin
            model_q.delete();
            head_id = '0;
        end else begin
            for (int w = 0; w < n_wb; w++) begin
                e      = model_q[wb_idx[w]];
                e.done = 1'b1;
                e.data = wb_data_i[w];
                e.exc  = wb_exc_i[w];
                model_q[wb_idx[w]] = e;
            end
            repeat (n_ret) begin
                void'(model_q.pop_front());
            end
            for (int d = 0; d < n_disp; d++) begin
                e.id    = head_id;
                e.areg  = disp_areg_i[d];
                e.pc    = disp_pc_i[d];
                e.w_reg = disp_w_reg_i[d];
                e.done  = 1'b0;
                e.data  = '0;
                e.exc   = 1'b0;
                model_q.push_back(e);
                head_id = head_id + rob_id_t'(1);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // traffic patterns and waits
    ////////////////////////////////////////////////////////////

    task automatic traffic(int n, int disp_pct, int wb_pct);
        if (timed_out) begin
            return;
        end
        p_disp = disp_pct;
        p_wb   = wb_pct;
        repeat (n) begin
            run_cycle();
        end
    endtask

    // dispatch without writebacks until full_o rises
    task automatic fill_to_full();
        int cyc;
        cyc    = 0;
        p_disp = 100;
        p_wb   = 0;
        while (!timed_out && !full_o && cyc < FILL_LIMIT) begin
            run_cycle();
            cyc++;
        end
        if (!timed_out && !full_o) begin
            $display("timeout: full_o did not rise within %0d cycles", FILL_LIMIT);
            timed_out = 1'b1;
            test_errs++;
        end
    endtask

    // writebacks only, until every entry has retired
    task automatic drain_model();
        int cyc;
        cyc    = 0;
        p_disp = 0;
        p_wb   = 100;
        while (!timed_out && model_q.size() != 0 && cyc < DRAIN_LIMIT) begin
            run_cycle();
            cyc++;
        end
        if (!timed_out && model_q.size() != 0) begin
            $display("timeout: ROB did not drain within %0d cycles", DRAIN_LIMIT);
            timed_out = 1'b1;
            test_errs++;
        end
    endtask

    task automatic start_test();
        test_errs     = 0;
        test_checks   = 0;
        dual_seen     = 0;
        src_done_seen = 0;
        src_wait_seen = 0;
    endtask

    task automatic close_test(string name);
        tests_run++;
        total_errs   += test_errs;
        total_checks += test_checks;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("test %-12s %6d checks %4d errors  %s", name, test_checks, test_errs,
                 (test_errs == 0) ? "ok" : "failed");
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        clk          = 1'b0;
        arst_n_i     = 1'b0;
        flush_i      = 1'b0;
        disp_valid_i = '0;
        disp_areg_i  = '0;
        disp_pc_i    = '0;
        disp_w_reg_i = '0;
        src_id_i     = '0;
        wb_valid_i   = '0;
        wb_id_i      = '0;
        wb_data_i    = '0;
        wb_exc_i     = '0;
        lcg_state    = LCG_SEED;
        head_id      = '0;
        p_disp       = 0;
        p_wb         = 0;
        force_flush  = 1'b0;
        timed_out    = 1'b0;
        total_errs   = 0;
        total_checks = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        // ids through the wrap, full level at both ends
        start_test();
        fill_to_full();
        drain_model();
        traffic(300, 70, 50);
        drain_model();
        close_test("allocation");

        // out of order writeback, in order commit
        start_test();
        traffic(400, 60, 45);
        drain_model();
        close_test("retirement");

        // heavy writeback so both slots retire together
        start_test();
        traffic(300, 90, 95);
        drain_model();
        check_seen("dual retirement", dual_seen);
        close_test("dual_retire");

        // sparse writeback leaves many pending operands
        start_test();
        traffic(300, 60, 30);
        drain_model();
        check_seen("operand read of a done entry", src_done_seen);
        check_seen("operand read of a pending entry", src_wait_seen);
        close_test("operands");

        // random flush points, restart from id 0
        start_test();
        repeat (6) begin
            traffic(10 + rand_below(60), 70, 40);
            force_flush = 1'b1;
            traffic(1, 70, 40);
            force_flush = 1'b0;
        end
        traffic(200, 70, 50);
        drain_model();
        close_test("flush");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, total_checks, total_errs);
        if (total_errs == 0 && tests_failed == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== rob_core.f ====
src/rob_pkg.sv
src/rob_if.sv
src/multiport_regfile.sv
src/rob_alloc.sv
src/complete_tracker.sv
src/rob_commit.sv
src/rob_top.sv
verif/rob_assert.sv
verif/rob_tb.sv

// ==== Makefile ====
# Verilator build and run for the reorder buffer

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= rob_tb
FILELIST  ?= rob_core.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= V$(TOP)
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with Verilator, run it, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)
	$(BUILD_DIR)/$(SIM_BIN) | tee $(LOG)
	@grep -qx '>>> PASS' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
